// File: tb.f
verilog/dma_axi_pkg.sv
verilog/dma_ctl_pkg.sv
verilog/dma_task_ctrl.sv
verilog/mm2s_sequencer.sv
verilog/axi_rd_master.sv
verilog/icash_dma.sv
test/axi_mem_model.sv
test/tb_icash_dma.sv

// File: Bender.yml
package:
  name: icash_dma

sources:
  - verilog/dma_axi_pkg.sv
  - verilog/dma_ctl_pkg.sv
  - verilog/dma_task_ctrl.sv
  - verilog/mm2s_sequencer.sv
  - verilog/axi_rd_master.sv
  - verilog/icash_dma.sv
  - target: test
    files:
      - test/axi_mem_model.sv
      - test/tb_icash_dma.sv

// File: test/tb_icash_dma.sv
`timescale 1ns/1ps

module tb_icash_dma;

  localparam int BURST_BEATS = 4;
  localparam int BEAT_BYTES  = 32;
  // beats over all five transfers
  localparam int TOTAL_BEATS = 8 + 10 + 6 + 12 + 64;
  // up to 20 cycles a beat with stalls and burst overhead plus reset and the pause
  localparam int MAX_CYCLES  = 20 * TOTAL_BEATS + 1000;

  logic                     clk;
  logic                     reset;
  logic [1:0]               ctl;
  dma_axi_pkg::axi_addr_t   vdnn_base;
  dma_ctl_pkg::xfer_len_t   vdnn_len;
  dma_axi_pkg::axi_addr_t   addn_base;
  dma_ctl_pkg::xfer_len_t   addn_len;
  logic                     dnn_idle;
  logic                     stall_en;
  logic                     done;
  logic                     busy;
  logic                     cash_ready;
  logic                     cur_sel;
  logic                     mem_lock;
  logic                     mem_wreq;
  dma_ctl_pkg::cache_addr_t mem_wadd;
  dma_axi_pkg::axi_data_t   mem_wdata;
  dma_axi_pkg::axi_addr_t   araddr;
  dma_axi_pkg::axi_len_t    arlen;
  dma_axi_pkg::axi_size_t   arsize;
  dma_axi_pkg::axi_burst_t  arburst;
  logic                     arvalid;
  logic                     arready;
  dma_axi_pkg::axi_data_t   rdata;
  logic                     rlast;
  logic                     rvalid;
  logic                     rready;

  // expectation of the running transfer
  logic                     exp_sel = 1'b0;
  logic                     exp_cur_sel = 1'b0;
  dma_axi_pkg::axi_addr_t   exp_base = '0;
  int                       exp_beats = 0;
  int                       xfer_id = 0;

  dma_axi_pkg::axi_data_t   shadow [0:2047];
  int                       beats_seen = 0;
  int                       writes_seen = 0;
  int                       mon_id = 0;
  dma_axi_pkg::axi_addr_t   next_addr = '0;
  int                       ar_left = 0;
  int                       ar_count = 0;
  int                       cycles = 0;

  icash_dma #(
    .BURST_BEATS (BURST_BEATS)
  ) dut0 (
    .clk (clk), .reset (reset), .i_ctl (ctl),
    .i_vdnn_base (vdnn_base), .i_vdnn_len (vdnn_len),
    .i_addn_base (addn_base), .i_addn_len (addn_len), .i_dnn_idle (dnn_idle),
    .o_done (done), .o_busy (busy), .o_cash_ready (cash_ready), .o_cur_sel (cur_sel),
    .o_mem_lock (mem_lock), .o_mem_wreq (mem_wreq), .o_mem_wadd (mem_wadd),
    .o_mem_wdata (mem_wdata),
    .o_m_axi_araddr (araddr), .o_m_axi_arlen (arlen), .o_m_axi_arsize (arsize),
    .o_m_axi_arburst (arburst), .o_m_axi_arvalid (arvalid), .i_m_axi_arready (arready),
    .i_m_axi_rdata (rdata), .i_m_axi_rlast (rlast), .i_m_axi_rvalid (rvalid),
    .o_m_axi_rready (rready)
  );

  axi_mem_model #(
    .SEED (32'hfff4)
  ) u_mem (
    .clk (clk), .reset (reset), .i_stall_en (stall_en),
    .i_araddr (araddr), .i_arlen (arlen), .i_arvalid (arvalid), .o_arready (arready),
    .o_rdata (rdata), .o_rlast (rlast), .o_rvalid (rvalid), .i_rready (rready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [255:0] exp_val,
                                 input logic [255:0] act_val);
    $display("[ERROR] t=%0t ns %s: expected %0h, actual %0h", $time, name, exp_val, act_val);
    abort_run();
  endtask

  task automatic report_problem(input string msg);
    $display("t=%0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    assert (act_val === exp_val) else report_mismatch(name, exp_val, act_val);
  endtask

  // cache word idx holds the DDR beat at base + idx * 32
  function automatic dma_axi_pkg::axi_data_t expected_word(input dma_axi_pkg::axi_addr_t base,
                                                           input int idx);
    dma_axi_pkg::axi_addr_t a;
    dma_axi_pkg::axi_data_t d;
    a = base + 42'(idx * BEAT_BYTES);
    for (int j = 0; j < 8; j++) begin
      d[32*j +: 32] = 32'(a + 42'(4 * j)) ^ {a[41:32], 22'h0a5a5};
    end
    return d;
  endfunction

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      report_problem($sformatf("timeout, no end of test after %0d cycles", cycles));
    end
  end

  //////////////////////////////////////////////////
  // cache shadow and completion check
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!reset) begin
      if (mem_wreq) begin
        assert (writes_seen < beats_seen)
          else report_problem("cache write request without an accepted beat");
        assert (mem_wadd === dma_ctl_pkg::cache_addr_t'(writes_seen))
          else report_mismatch("o_mem_wadd", writes_seen, mem_wadd);
        shadow[mem_wadd] = mem_wdata;
        writes_seen = writes_seen + 1;
      end
      if (rvalid && rready) begin
        beats_seen = beats_seen + 1;
      end
      if (done) begin
        assert (beats_seen == exp_beats)
          else report_mismatch("accepted beats", exp_beats, beats_seen);
        assert (writes_seen == exp_beats)
          else report_mismatch("o_mem_wreq count", exp_beats, writes_seen);
        for (int i = 0; i < exp_beats; i++) begin
          assert (shadow[i] === expected_word(exp_base, i))
            else report_mismatch($sformatf("o_mem_wdata word %0d", i),
                                 expected_word(exp_base, i), shadow[i]);
        end
        assert (ar_left == 0) else report_problem("done before all bursts were requested");
        beats_seen  = 0;
        writes_seen = 0;
      end
    end
  end

  // every AR carries the next address and the smaller of 4 and the remaining beats
  always @(posedge clk) begin
    int burst_n;
    if (xfer_id != mon_id) begin
      mon_id    = xfer_id;
      next_addr = exp_base;
      ar_left   = exp_beats;
    end
    if (!reset && arvalid && arready) begin
      burst_n = (ar_left < BURST_BEATS) ? ar_left : BURST_BEATS;
      assert (ar_left > 0) else report_problem("AR burst beyond the end of the transfer");
      assert (araddr === next_addr) else report_mismatch("o_m_axi_araddr", next_addr, araddr);
      assert (int'(arlen) == burst_n - 1)
        else report_mismatch("o_m_axi_arlen", burst_n - 1, arlen);
      assert (arsize === 3'd5) else report_mismatch("o_m_axi_arsize", 3'd5, arsize);
      assert (arburst === 2'b01) else report_mismatch("o_m_axi_arburst", 2'b01, arburst);
      next_addr = next_addr + 42'(BURST_BEATS * BEAT_BYTES);
      ar_left   = ar_left - burst_n;
      ar_count  = ar_count + 1;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic arm_expect(input logic sel);
    exp_sel   = sel;
    exp_base  = sel ? vdnn_base : addn_base;
    exp_beats = int'(sel ? vdnn_len : addn_len) / BEAT_BYTES;
    xfer_id   = xfer_id + 1;
  endtask

  task automatic wait_done();
    logic seen;
    logic first;
    seen  = 1'b0;
    first = 1'b1;
    while (!seen) begin
      @(posedge clk);
      check_bit("o_busy", 1'b1, busy);
      // selection moves only once the copy is complete
      check_bit("o_cur_sel", exp_cur_sel, cur_sel);
      if (!first) begin
        check_bit("o_cash_ready", 1'b0, cash_ready);
      end
      first = 1'b0;
      seen  = done;
    end
    @(posedge clk);
    check_bit("o_done", 1'b0, done);
    check_bit("o_cash_ready", 1'b1, cash_ready);
    check_bit("o_cur_sel", exp_sel, cur_sel);
    check_bit("o_busy", 1'b0, busy);
    check_bit("o_mem_lock", 1'b1, mem_lock);
    exp_cur_sel = exp_sel;
    #1;
  endtask

  task automatic wait_beat();
    do begin
      @(posedge clk);
    end while (!(rvalid && rready));
    #1;
  endtask

  task automatic hold_paused(input int n);
    int ar_before;
    ar_before = ar_count;
    repeat (n) begin
      @(posedge clk);
      check_bit("o_mem_lock", 1'b1, mem_lock);
      check_bit("o_busy", 1'b1, busy);
    end
    // burst in flight has drained by now
    check_bit("o_m_axi_rready", 1'b0, rready);
    check_bit("o_m_axi_arvalid", 1'b0, arvalid);
    #1;
    assert (ar_count == ar_before) else report_problem("new AR burst issued during the pause");
  endtask

  initial begin
    reset     = 1'b1;
    ctl       = 2'b00;
    vdnn_base = '0;
    vdnn_len  = '0;
    addn_base = '0;
    addn_len  = '0;
    dnn_idle  = 1'b1;
    stall_en  = 1'b0;
    repeat (8) @(posedge clk);
    check_bit("o_done", 1'b0, done);
    check_bit("o_mem_wreq", 1'b0, mem_wreq);
    check_bit("o_m_axi_arvalid", 1'b0, arvalid);
    check_bit("o_m_axi_rready", 1'b0, rready);
    check_bit("o_busy", 1'b0, busy);
    check_bit("o_cash_ready", 1'b0, cash_ready);
    check_bit("o_mem_lock", 1'b1, mem_lock);
    #1;
    reset = 1'b0;

    // vdnn source with two full bursts
    vdnn_base = 42'h2_0000_1000;
    vdnn_len  = 16'd256;
    ctl       = 2'b01;
    @(posedge clk);
    #1;
    arm_expect(1'b1);
    ctl = 2'b11;
    wait_done();

    // addn source of 10 beats ends on a short burst
    addn_base = 42'h0_8000_0400;
    addn_len  = 16'd320;
    ctl       = 2'b00;
    @(posedge clk);
    #1;
    arm_expect(1'b0);
    ctl = 2'b10;
    wait_done();

    // select toggle with enable held
    vdnn_base = 42'h1_2345_6780;
    vdnn_len  = 16'd192;
    arm_expect(1'b1);
    ctl = 2'b11;
    wait_done();

    // accelerator busy in the middle of a transfer
    addn_base = 42'h3_ff00_0fe0;
    addn_len  = 16'd384;
    arm_expect(1'b0);
    ctl = 2'b10;
    wait_beat();
    dnn_idle = 1'b0;
    hold_paused(40);
    dnn_idle = 1'b1;
    wait_done();

    // long copy with random AR and R stalls
    vdnn_base = 42'h0_0000_2000;
    vdnn_len  = 16'd2048;
    stall_en  = 1'b1;
    ctl       = 2'b01;
    @(posedge clk);
    #1;
    arm_expect(1'b1);
    ctl = 2'b11;
    wait_done();

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: test/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
  parameter logic [31:0] SEED = 32'hfff4
) (
  input  logic                   clk,
  input  logic                   reset,
  // random arready and rvalid gaps when high
  input  logic                   i_stall_en,
  input  dma_axi_pkg::axi_addr_t i_araddr,
  input  dma_axi_pkg::axi_len_t  i_arlen,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  output dma_axi_pkg::axi_data_t o_rdata,
  output logic                   o_rlast,
  output logic                   o_rvalid,
  input  logic                   i_rready
);

  logic [31:0]            rnd;
  logic                   active;
  logic                   ar_fire;
  logic                   r_fire;
  dma_axi_pkg::axi_addr_t addr;
  int                     left;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // each 32-bit lane holds its own byte address, folded with the top address bits
  function automatic dma_axi_pkg::axi_data_t beat_at(input dma_axi_pkg::axi_addr_t a);
    dma_axi_pkg::axi_data_t d;
    for (int j = 0; j < 8; j++) begin
      d[32*j +: 32] = 32'(a + 42'(4 * j)) ^ {a[41:32], 22'h0a5a5};
    end
    return d;
  endfunction

  initial begin
    rnd       = SEED;
    active    = 1'b0;
    addr      = '0;
    left      = 0;
    o_arready = 1'b0;
    o_rvalid  = 1'b0;
    o_rlast   = 1'b0;
    o_rdata   = '0;
  end

  //////////////////////////////////////////////////
  // one burst at a time
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    ar_fire = i_arvalid && o_arready;
    r_fire  = o_rvalid && i_rready;
    if (reset) begin
      active = 1'b0;
      left   = 0;
    end else begin
      if (r_fire) begin
        addr = addr + 42'(dma_axi_pkg::BEAT_BYTES);
        left = left - 1;
        if (left == 0) begin
          active = 1'b0;
        end
      end
      if (ar_fire) begin
        addr   = i_araddr;
        left   = int'(i_arlen) + 1;
        active = 1'b1;
      end
    end
    #1;
    rnd = lcg_next(rnd);
    if (reset) begin
      o_arready = 1'b0;
      o_rvalid  = 1'b0;
      o_rlast   = 1'b0;
    end else begin
      o_arready = !active && (!i_stall_en || rnd[31:29] >= 3'd3);
      // a raised rvalid holds until the beat is taken
      if (!o_rvalid || r_fire) begin
        o_rvalid = active && (!i_stall_en || rnd[28:26] >= 3'd3);
      end
      o_rdata = beat_at(addr);
      o_rlast = (left == 1);
    end
  end

endmodule

// File: verilog/icash_dma.sv
`timescale 1ns/1ps

module icash_dma #(
  parameter int BURST_BEATS = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  // host control
  input  logic [1:0]               i_ctl,
  input  dma_axi_pkg::axi_addr_t   i_vdnn_base,
  input  dma_ctl_pkg::xfer_len_t   i_vdnn_len,
  input  dma_axi_pkg::axi_addr_t   i_addn_base,
  input  dma_ctl_pkg::xfer_len_t   i_addn_len,
  input  logic                     i_dnn_idle,
  // status
  output logic                     o_done,
  output logic                     o_busy,
  output logic                     o_cash_ready,
  output logic                     o_cur_sel,
  // cache memory write port
  output logic                     o_mem_lock,
  output logic                     o_mem_wreq,
  output dma_ctl_pkg::cache_addr_t o_mem_wadd,
  output dma_axi_pkg::axi_data_t   o_mem_wdata,
  // AXI read address
  output dma_axi_pkg::axi_addr_t   o_m_axi_araddr,
  output dma_axi_pkg::axi_len_t    o_m_axi_arlen,
  output dma_axi_pkg::axi_size_t   o_m_axi_arsize,
  output dma_axi_pkg::axi_burst_t  o_m_axi_arburst,
  output logic                     o_m_axi_arvalid,
  input  logic                     i_m_axi_arready,
  // AXI read data
  input  dma_axi_pkg::axi_data_t   i_m_axi_rdata,
  input  logic                     i_m_axi_rlast,
  input  logic                     i_m_axi_rvalid,
  output logic                     o_m_axi_rready
);

  logic                   run;
  dma_axi_pkg::axi_addr_t xfer_base;
  dma_ctl_pkg::xfer_len_t xfer_len;
  logic                   burst_req;
  dma_axi_pkg::axi_addr_t burst_addr;
  dma_axi_pkg::axi_len_t  burst_len;
  logic                   burst_done;
  logic                   beat_valid;
  dma_axi_pkg::axi_data_t beat_data;

  // control chain is task ctrl, sequencer, read master
  dma_task_ctrl u_task_ctrl (
    .clk          (clk),
    .reset        (reset),
    .i_ctl        (i_ctl),
    .i_vdnn_base  (i_vdnn_base),
    .i_addn_base  (i_addn_base),
    .i_vdnn_len   (i_vdnn_len),
    .i_addn_len   (i_addn_len),
    .i_dnn_idle   (i_dnn_idle),
    .i_done       (o_done),
    .o_run        (run),
    .o_base       (xfer_base),
    .o_len        (xfer_len),
    .o_busy       (o_busy),
    .o_cash_ready (o_cash_ready),
    .o_cur_sel    (o_cur_sel),
    .o_mem_lock   (o_mem_lock)
  );

  mm2s_sequencer #(
    .BURST_BEATS (BURST_BEATS)
  ) u_sequencer (
    .clk          (clk),
    .reset        (reset),
    .i_run        (run),
    .i_base       (xfer_base),
    .i_len        (xfer_len),
    .o_done       (o_done),
    .o_burst_req  (burst_req),
    .o_burst_addr (burst_addr),
    .o_burst_len  (burst_len),
    .i_burst_done (burst_done),
    .i_beat_valid (beat_valid),
    .i_beat_data  (beat_data),
    .o_mem_wreq   (o_mem_wreq),
    .o_mem_wadd   (o_mem_wadd),
    .o_mem_wdata  (o_mem_wdata)
  );

  axi_rd_master u_rd_master (
    .clk             (clk),
    .reset           (reset),
    .i_burst_req     (burst_req),
    .i_burst_addr    (burst_addr),
    .i_burst_len     (burst_len),
    .o_burst_done    (burst_done),
    .o_beat_valid    (beat_valid),
    .o_beat_data     (beat_data),
    .o_m_axi_araddr  (o_m_axi_araddr),
    .o_m_axi_arlen   (o_m_axi_arlen),
    .o_m_axi_arsize  (o_m_axi_arsize),
    .o_m_axi_arburst (o_m_axi_arburst),
    .o_m_axi_arvalid (o_m_axi_arvalid),
    .i_m_axi_arready (i_m_axi_arready),
    .i_m_axi_rdata   (i_m_axi_rdata),
    .i_m_axi_rlast   (i_m_axi_rlast),
    .i_m_axi_rvalid  (i_m_axi_rvalid),
    .o_m_axi_rready  (o_m_axi_rready)
  );

endmodule

// File: verilog/axi_rd_master.sv
`timescale 1ns/1ps

module axi_rd_master (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    i_burst_req,
  input  dma_axi_pkg::axi_addr_t  i_burst_addr,
  input  dma_axi_pkg::axi_len_t   i_burst_len,
  output logic                    o_burst_done,
  output logic                    o_beat_valid,
  output dma_axi_pkg::axi_data_t  o_beat_data,
  // read address channel
  output dma_axi_pkg::axi_addr_t  o_m_axi_araddr,
  output dma_axi_pkg::axi_len_t   o_m_axi_arlen,
  output dma_axi_pkg::axi_size_t  o_m_axi_arsize,
  output dma_axi_pkg::axi_burst_t o_m_axi_arburst,
  output logic                    o_m_axi_arvalid,
  input  logic                    i_m_axi_arready,
  // read data channel
  input  dma_axi_pkg::axi_data_t  i_m_axi_rdata,
  input  logic                    i_m_axi_rlast,
  input  logic                    i_m_axi_rvalid,
  output logic                    o_m_axi_rready
);

  dma_ctl_pkg::rd_state_t state_q;
  dma_axi_pkg::axi_addr_t araddr_q;
  dma_axi_pkg::axi_len_t  arlen_q;
  dma_axi_pkg::axi_len_t  beat_q;
  logic                   beat_fire;
  logic                   last_beat;

  assign beat_fire = i_m_axi_rvalid && o_m_axi_rready;
  assign last_beat = (beat_q == arlen_q);

  //////////////////////////////////////////////////
  // one burst in flight
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= dma_ctl_pkg::RD_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        dma_ctl_pkg::RD_IDLE: begin
          if (i_burst_req) begin
            state_q <= dma_ctl_pkg::RD_ADDR;
          end
        end
        dma_ctl_pkg::RD_ADDR: begin
          if (i_m_axi_arready) begin
            beat_q  <= '0;
            state_q <= dma_ctl_pkg::RD_DATA;
          end
        end
        default: begin
          if (beat_fire) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              state_q <= dma_ctl_pkg::RD_IDLE;
            end
          end
        end
      endcase
    end
  end

  // address and length held from request until AR handshake
  always_ff @(posedge clk) begin
    if (state_q == dma_ctl_pkg::RD_IDLE && i_burst_req) begin
      araddr_q <= i_burst_addr;
      arlen_q  <= i_burst_len;
    end
  end

  assign o_m_axi_araddr  = araddr_q;
  assign o_m_axi_arlen   = arlen_q;
  assign o_m_axi_arsize  = dma_axi_pkg::AXI_SIZE_32B;
  assign o_m_axi_arburst = dma_axi_pkg::AXI_BURST_INCR;
  assign o_m_axi_arvalid = (state_q == dma_ctl_pkg::RD_ADDR);
  assign o_m_axi_rready  = (state_q == dma_ctl_pkg::RD_DATA);

  // beats pass straight through and the sequencer registers them
  assign o_beat_valid = beat_fire;
  assign o_beat_data  = i_m_axi_rdata;
  assign o_burst_done = beat_fire && last_beat;

  // slave must close the burst on the beat arlen promised
  a_rlast_match: assert property (@(posedge clk) disable iff (reset)
    beat_fire |-> (i_m_axi_rlast == last_beat));

  a_ar_stable: assert property (@(posedge clk) disable iff (reset)
    o_m_axi_arvalid && !i_m_axi_arready |=>
      o_m_axi_arvalid && $stable(o_m_axi_araddr) && $stable(o_m_axi_arlen));

endmodule

// File: verilog/mm2s_sequencer.sv
`timescale 1ns/1ps

module mm2s_sequencer #(
  parameter int BURST_BEATS = 16
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_run,
  input  dma_axi_pkg::axi_addr_t   i_base,
  input  dma_ctl_pkg::xfer_len_t   i_len,
  output logic                     o_done,
  output logic                     o_burst_req,
  output dma_axi_pkg::axi_addr_t   o_burst_addr,
  output dma_axi_pkg::axi_len_t    o_burst_len,
  input  logic                     i_burst_done,
  input  logic                     i_beat_valid,
  input  dma_axi_pkg::axi_data_t   i_beat_data,
  output logic                     o_mem_wreq,
  output dma_ctl_pkg::cache_addr_t o_mem_wadd,
  output dma_axi_pkg::axi_data_t   o_mem_wdata
);

  localparam dma_ctl_pkg::beat_cnt_t MAX_BEATS = dma_ctl_pkg::beat_cnt_t'(BURST_BEATS);
  localparam dma_axi_pkg::axi_addr_t BURST_BYTES =
    dma_axi_pkg::axi_addr_t'(BURST_BEATS * dma_axi_pkg::BEAT_BYTES);

  dma_ctl_pkg::seq_state_t  state_q;
  dma_ctl_pkg::beat_cnt_t   rem_q;
  dma_ctl_pkg::beat_cnt_t   burst_beats;
  dma_ctl_pkg::beat_cnt_t   total_beats;
  dma_axi_pkg::axi_addr_t   addr_q;
  dma_ctl_pkg::cache_addr_t wptr_q;
  logic                     done_q;
  logic                     req_q;
  dma_axi_pkg::axi_addr_t   req_addr_q;
  dma_axi_pkg::axi_len_t    req_len_q;
  logic                     wreq_q;
  dma_ctl_pkg::cache_addr_t wadd_q;
  dma_axi_pkg::axi_data_t   wdata_q;

  assign total_beats = dma_ctl_pkg::beat_cnt_t'(i_len / dma_axi_pkg::BEAT_BYTES);

  // last burst may be short
  assign burst_beats = (rem_q > MAX_BEATS) ? MAX_BEATS : rem_q;

  //////////////////////////////////////////////////
  // burst scheduling
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= dma_ctl_pkg::SEQ_IDLE;
      rem_q   <= '0;
      addr_q  <= '0;
      done_q  <= 1'b0;
      req_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      req_q  <= 1'b0;
      case (state_q)
        dma_ctl_pkg::SEQ_IDLE: begin
          // run is still high while the done pulse is out
          if (i_run && !done_q) begin
            rem_q   <= total_beats;
            addr_q  <= i_base;
            state_q <= (total_beats == '0) ? dma_ctl_pkg::SEQ_FINISH
                                           : dma_ctl_pkg::SEQ_ISSUE;
          end
        end
        dma_ctl_pkg::SEQ_ISSUE: begin
          // hold off new bursts while paused
          if (i_run) begin
            req_q   <= 1'b1;
            rem_q   <= rem_q - burst_beats;
            addr_q  <= addr_q + BURST_BYTES;
            state_q <= dma_ctl_pkg::SEQ_WAIT_BURST;
          end
        end
        dma_ctl_pkg::SEQ_WAIT_BURST: begin
          if (i_burst_done) begin
            state_q <= (rem_q == '0) ? dma_ctl_pkg::SEQ_FINISH
                                     : dma_ctl_pkg::SEQ_ISSUE;
          end
        end
        default: begin
          done_q  <= 1'b1;
          state_q <= dma_ctl_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (state_q == dma_ctl_pkg::SEQ_ISSUE && i_run) begin
      req_addr_q <= addr_q;
      req_len_q  <= dma_axi_pkg::axi_len_t'(burst_beats - dma_ctl_pkg::beat_cnt_t'(1));
    end
  end

  //////////////////////////////////////////////////
  // cache write port
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wreq_q <= 1'b0;
      wptr_q <= '0;
    end else begin
      wreq_q <= i_beat_valid;
      if (state_q == dma_ctl_pkg::SEQ_IDLE) begin
        wptr_q <= '0;
      end else if (i_beat_valid) begin
        wptr_q <= wptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_beat_valid) begin
      wadd_q  <= wptr_q;
      wdata_q <= i_beat_data;
    end
  end

  assign o_done       = done_q;
  assign o_burst_req  = req_q;
  assign o_burst_addr = req_addr_q;
  assign o_burst_len  = req_len_q;
  assign o_mem_wreq   = wreq_q;
  assign o_mem_wadd   = wadd_q;
  assign o_mem_wdata  = wdata_q;

  // the read master only returns beats for a burst we asked for
  a_beat_in_burst: assert property (@(posedge clk) disable iff (reset)
    i_beat_valid |-> state_q == dma_ctl_pkg::SEQ_WAIT_BURST);

endmodule

// File: verilog/dma_task_ctrl.sv
`timescale 1ns/1ps

module dma_task_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  // bit 1 enable, bit 0 source select
  input  logic [1:0]            i_ctl,
  input  dma_axi_pkg::axi_addr_t i_vdnn_base,
  input  dma_axi_pkg::axi_addr_t i_addn_base,
  input  dma_ctl_pkg::xfer_len_t i_vdnn_len,
  input  dma_ctl_pkg::xfer_len_t i_addn_len,
  input  logic                  i_dnn_idle,
  input  logic                  i_done,
  output logic                  o_run,
  output dma_axi_pkg::axi_addr_t o_base,
  output dma_ctl_pkg::xfer_len_t o_len,
  output logic                  o_busy,
  output logic                  o_cash_ready,
  output logic                  o_cur_sel,
  output logic                  o_mem_lock
);

  logic                   ctl_en;
  logic                   ctl_sel;
  logic                   en_q;
  logic                   sel_q;
  logic                   start;
  logic                   task_q;
  logic                   cash_ready_q;
  logic                   cur_sel_q;
  logic                   sel_latch_q;
  dma_axi_pkg::axi_addr_t base_q;
  dma_ctl_pkg::xfer_len_t len_q;

  assign ctl_en  = i_ctl[1];
  assign ctl_sel = i_ctl[0];

  //////////////////////////////////////////////////
  // start event detection
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      en_q  <= 1'b0;
      sel_q <= 1'b0;
    end else begin
      en_q  <= ctl_en;
      sel_q <= ctl_sel;
    end
  end

  // rising enable, or a source switch while enabled
  assign start = ctl_en && (!en_q || (ctl_sel != sel_q));

  // source descriptor captured at the event
  always_ff @(posedge clk) begin
    if (start) begin
      base_q <= ctl_sel ? i_vdnn_base : i_addn_base;
      len_q  <= ctl_sel ? i_vdnn_len  : i_addn_len;
    end
  end

  //////////////////////////////////////////////////
  // task and status flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      task_q       <= 1'b0;
      cash_ready_q <= 1'b0;
      sel_latch_q  <= 1'b0;
      cur_sel_q    <= 1'b0;
    end else begin
      if (start) begin
        task_q      <= 1'b1;
        sel_latch_q <= ctl_sel;
      end else if (i_done) begin
        task_q <= 1'b0;
      end
      // a new event wins over a finishing one
      if (start) begin
        cash_ready_q <= 1'b0;
      end else if (i_done) begin
        cash_ready_q <= 1'b1;
      end
      // cache now holds the source of the finished task
      if (i_done) begin
        cur_sel_q <= sel_latch_q;
      end
    end
  end

  // sequencer only advances while the accelerator is idle
  assign o_run        = task_q && i_dnn_idle;
  assign o_mem_lock   = !o_run;
  assign o_busy       = start || task_q;
  assign o_cash_ready = cash_ready_q;
  assign o_cur_sel    = cur_sel_q;
  assign o_base       = base_q;
  assign o_len        = len_q;

  // done from the sequencer belongs to a task we started
  a_done_in_task: assert property (@(posedge clk) disable iff (reset)
    i_done |-> task_q);

endmodule

// File: verilog/dma_ctl_pkg.sv
package dma_ctl_pkg;

  //////////////////////////////////////////////////
  // transfer bookkeeping
  //////////////////////////////////////////////////

  // byte length up to 32 KB
  localparam int XFER_LEN_W = 16;

  // 32 KB of 32 B beats needs 11 bits
  localparam int BEAT_CNT_W = 11;

  // cache word address
  localparam int CACHE_ADDR_W = 11;

  typedef logic [XFER_LEN_W-1:0]   xfer_len_t;
  typedef logic [BEAT_CNT_W-1:0]   beat_cnt_t;
  typedef logic [CACHE_ADDR_W-1:0] cache_addr_t;

  //////////////////////////////////////////////////
  // state machines
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT_BURST,
    SEQ_FINISH
  } seq_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

endpackage

// File: verilog/dma_axi_pkg.sv
package dma_axi_pkg;

  //////////////////////////////////////////////////
  // read channel widths
  //////////////////////////////////////////////////

  // DDR byte address
  localparam int ADDR_W = 42;

  // one beat of read data
  localparam int DATA_W = 256;

  // arlen field
  localparam int LEN_W = 8;

  typedef logic [ADDR_W-1:0] axi_addr_t;
  typedef logic [DATA_W-1:0] axi_data_t;
  typedef logic [LEN_W-1:0]  axi_len_t;
  typedef logic [2:0]        axi_size_t;
  typedef logic [1:0]        axi_burst_t;

  //////////////////////////////////////////////////
  // fixed encodings
  //////////////////////////////////////////////////

  // bytes moved by a single beat
  localparam int BEAT_BYTES = DATA_W / 8;

  // arsize is log2 of the beat size
  localparam axi_size_t AXI_SIZE_32B = axi_size_t'($clog2(BEAT_BYTES));

  // incrementing burst
  localparam axi_burst_t AXI_BURST_INCR = 2'b01;

endpackage
